/* stlb_settings.svh */
`ifndef STLB_SETTINGS_SVH
`define STLB_SETTINGS_SVH

// ==================================================
// Geometry of the shared TLB
// ==================================================

// Number of entries and the index width that selects one of them
`define STLB_ENTRIES 256
`define STLB_LOG_ENTRIES 8

// Virtual and physical address widths
`define STLB_VA_W 32
`define STLB_PA_W 32

// Page offset width, 8 KiB pages
`define STLB_PAGE_SHIFT 13

// Address-space ID width
`define STLB_ASID_W 8

// Virtual page bits above the index, stored as the tag
`define STLB_TAG_W (`STLB_VA_W - `STLB_PAGE_SHIFT - `STLB_LOG_ENTRIES)

// Physical page number width
`define STLB_PPN_W (`STLB_PA_W - `STLB_PAGE_SHIFT)

`endif

/* stlb_pkg.sv */
`include "stlb_settings.svh"

package stlb_pkg;

	// ==================================================
	// Controller state
	// ==================================================

	// Reset sweep, normal operation and the invalidate-all sweep
	typedef enum logic [1:0] {
		ST_RST,
		ST_RUN,
		ST_INVALL
	} stlb_state_t;

	// ==================================================
	// Stored entry, 42 bits
	// ==================================================

	// Perm bits are read, write, execute from msb to lsb
	typedef struct packed {
		logic                      valid;
		logic [`STLB_ASID_W-1:0]   asid;
		logic [`STLB_TAG_W-1:0]    tag;
		logic [`STLB_PPN_W-1:0]    ppn;
		logic [2:0]                perm;
	} stlb_entry_t;

	// ==================================================
	// Wishbone data word and its four decodings
	// ==================================================

	// Upper half of an entry: valid, ASID and tag
	typedef struct packed {
		logic [31-`STLB_ASID_W-`STLB_TAG_W-1:0] rsvd;
		logic                                   valid;
		logic [`STLB_ASID_W-1:0]                asid;
		logic [`STLB_TAG_W-1:0]                 tag;
	} stlb_hi_word_t;

	// Lower half of an entry: physical page and permissions
	typedef struct packed {
		logic [32-`STLB_PPN_W-3-1:0] rsvd;
		logic [`STLB_PPN_W-1:0]      ppn;
		logic [2:0]                  perm;
	} stlb_lo_word_t;

	// Target index of a commit, held in the low bits
	typedef struct packed {
		logic [32-`STLB_LOG_ENTRIES-1:0] rsvd;
		logic [`STLB_LOG_ENTRIES-1:0]    idx;
	} stlb_index_word_t;

	// Command word, bit 0 starts invalidate-all and bit 1 reads as busy
	typedef struct packed {
		logic [29:0] rsvd;
		logic        busy;
		logic        invall;
	} stlb_cmd_word_t;

	// The register address picks which view applies to a word
	typedef union packed {
		stlb_hi_word_t    hi;
		stlb_lo_word_t    lo;
		stlb_index_word_t index;
		stlb_cmd_word_t   cmd;
	} stlb_wb_word_u;

	// Word registers, selected by address bits 3:2
	typedef enum logic [1:0] {
		REG_HI    = 2'd0,
		REG_LO    = 2'd1,
		REG_INDEX = 2'd2,
		REG_CMD   = 2'd3
	} stlb_reg_t;

endpackage

/* stlb_ram_if.sv */
`include "stlb_settings.svh"

interface stlb_ram_if;

	// Write port, fed by the address/data selector
	logic                          we;
	logic [`STLB_LOG_ENTRIES-1:0]  wadr;
	stlb_pkg::stlb_entry_t         wdat;

	// Read port, owned by the lookup pipeline
	logic [`STLB_LOG_ENTRIES-1:0]  radr;
	stlb_pkg::stlb_entry_t         rdat;

	// Writer side
	modport wr (
		output we,
		output wadr,
		output wdat
	);

	// Storage side sees both ports
	modport mem (
		input  we,
		input  wadr,
		input  wdat,
		input  radr,
		output rdat
	);

	// Reader side
	modport rd (
		output radr,
		input  rdat
	);

endinterface

/* stlb_ctrl.sv */
`include "stlb_settings.svh"

module stlb_ctrl (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         inv_req,
	output stlb_pkg::stlb_state_t        state,
	output logic [`STLB_LOG_ENTRIES-1:0] sweep_index
);

	// Index of the final entry, where a sweep ends
	localparam logic [`STLB_LOG_ENTRIES-1:0] LAST_INDEX = `STLB_LOG_ENTRIES'(`STLB_ENTRIES - 1);

	// ==================================================
	// State register and sweep counter
	// ==================================================

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			// Every entry must be cleared before the buffer can be used
			state <= stlb_pkg::ST_RST;
			sweep_index <= '0;
		end
		else
		begin
			case (state)
				stlb_pkg::ST_RST,
				stlb_pkg::ST_INVALL:
				begin
					// One index per cycle, the counter wraps back to zero at the end
					sweep_index <= sweep_index + 1'b1;
					if (sweep_index == LAST_INDEX)
					begin
						state <= stlb_pkg::ST_RUN;
					end
				end
				stlb_pkg::ST_RUN:
				begin
					// A software request restarts the sweep from index zero
					if (inv_req)
					begin
						state <= stlb_pkg::ST_INVALL;
						sweep_index <= '0;
					end
				end
				default:
				begin
					// Unused encoding, fall back to normal operation
					state <= stlb_pkg::ST_RUN;
					sweep_index <= '0;
				end
			endcase
		end
	end

endmodule

/* stlb_ad_mux.sv */
`include "stlb_settings.svh"

module stlb_ad_mux (
	input  logic                         clk,
	input  stlb_pkg::stlb_state_t        state,
	input  logic [`STLB_LOG_ENTRIES-1:0] sweep_index,
	input  logic                         commit,
	input  logic [`STLB_LOG_ENTRIES-1:0] commit_index,
	input  stlb_pkg::stlb_entry_t        commit_entry,
	stlb_ram_if.wr                       ram
);

	// ==================================================
	// Write address and data selection
	// ==================================================

	// The entry memory has a single write port, so the sweep and
	// software commits share it and the state picks the source
	always_ff @(posedge clk)
	begin
		case (state)
			stlb_pkg::ST_RST,
			stlb_pkg::ST_INVALL:
			begin
				// Sweeps store an all-zero entry, which clears the valid bit
				ram.we <= 1'b1;
				ram.wadr <= sweep_index;
				ram.wdat <= '0;
			end
			stlb_pkg::ST_RUN:
			begin
				// Only the commit pulse from the register block writes
				ram.we <= commit;
				ram.wadr <= commit_index;
				ram.wdat <= commit_entry;
			end
			default:
			begin
				// Nothing is written from an unused state encoding
				ram.we <= 1'b0;
				ram.wadr <= commit_index;
				ram.wdat <= commit_entry;
			end
		endcase
	end

endmodule

/* stlb_ram.sv */
`include "stlb_settings.svh"

module stlb_ram (
	input  logic     clk,
	stlb_ram_if.mem  port
);

	// ==================================================
	// Entry storage
	// ==================================================

	// One entry per index, direct mapped
	stlb_pkg::stlb_entry_t mem [`STLB_ENTRIES];

	// Synchronous write port
	always_ff @(posedge clk)
	begin
		if (port.we)
		begin
			mem[port.wadr] <= port.wdat;
		end
	end

	// Registered read port
	// A read of the index being written in the same cycle returns the old entry
	always_ff @(posedge clk)
	begin
		port.rdat <= mem[port.radr];
	end

endmodule

/* stlb_wb_regs.sv */
`include "stlb_settings.svh"

module stlb_wb_regs (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         wb_cyc,
	input  logic                         wb_stb,
	input  logic                         wb_we,
	input  logic [3:0]                   wb_adr,
	input  logic [31:0]                  wb_dat_i,
	output logic [31:0]                  wb_dat_o,
	output logic                         wb_ack,
	input  stlb_pkg::stlb_state_t        state,
	output logic                         commit,
	output logic [`STLB_LOG_ENTRIES-1:0] commit_index,
	output stlb_pkg::stlb_entry_t        commit_entry,
	output logic                         inv_req,
	output logic                         busy
);

	// Register selected by the word address
	stlb_pkg::stlb_reg_t reg_sel;

	// Incoming and outgoing data words, decoded through the union
	stlb_pkg::stlb_wb_word_u wr_word;
	stlb_pkg::stlb_wb_word_u rd_word;

	// Entry staged by software before it is committed
	stlb_pkg::stlb_entry_t staged;

	// An access that will be acknowledged at the next edge
	logic access;

	assign reg_sel = stlb_pkg::stlb_reg_t'(wb_adr[3:2]);
	assign wr_word = wb_dat_i;

	// Anything other than normal operation is a sweep in progress
	assign busy = (state != stlb_pkg::ST_RUN);

	// Ack is withheld during a sweep, which stalls the master
	// The ack term keeps a held request from being taken twice
	assign access = wb_cyc & wb_stb & ~wb_ack & ~busy;

	assign commit_entry = staged;

	// ==================================================
	// Read data
	// ==================================================

	always_comb
	begin
		rd_word = '0;
		case (reg_sel)
			stlb_pkg::REG_HI:
			begin
				rd_word.hi.valid = staged.valid;
				rd_word.hi.asid = staged.asid;
				rd_word.hi.tag = staged.tag;
			end
			stlb_pkg::REG_LO:
			begin
				rd_word.lo.ppn = staged.ppn;
				rd_word.lo.perm = staged.perm;
			end
			stlb_pkg::REG_INDEX:
			begin
				rd_word.index.idx = commit_index;
			end
			default:
			begin
				// Invalidate-all is a command and always reads as zero
				rd_word.cmd.busy = busy;
			end
		endcase
	end

	// ==================================================
	// Handshake and command pulses
	// ==================================================

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wb_ack <= 1'b0;
			commit <= 1'b0;
			inv_req <= 1'b0;
		end
		else
		begin
			wb_ack <= access;
			commit <= access & wb_we & (reg_sel == stlb_pkg::REG_INDEX);
			inv_req <= access & wb_we & (reg_sel == stlb_pkg::REG_CMD) & wr_word.cmd.invall;
		end
	end

	// ==================================================
	// Staging registers and read-back
	// ==================================================

	always_ff @(posedge clk)
	begin
		if (access)
		begin
			// Read data is valid in the ack cycle
			wb_dat_o <= rd_word;
			if (wb_we)
			begin
				case (reg_sel)
					stlb_pkg::REG_HI:
					begin
						staged.valid <= wr_word.hi.valid;
						staged.asid <= wr_word.hi.asid;
						staged.tag <= wr_word.hi.tag;
					end
					stlb_pkg::REG_LO:
					begin
						staged.ppn <= wr_word.lo.ppn;
						staged.perm <= wr_word.lo.perm;
					end
					stlb_pkg::REG_INDEX:
					begin
						// Index is captured together with the commit pulse
						commit_index <= wr_word.index.idx;
					end
					default:
					begin
						staged <= staged;
					end
				endcase
			end
		end
	end

endmodule

/* stlb_lookup.sv */
`include "stlb_settings.svh"

module stlb_lookup (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     lk_req,
	input  logic [`STLB_VA_W-1:0]    lk_va,
	input  logic [`STLB_ASID_W-1:0]  lk_asid,
	stlb_ram_if.rd                   ram,
	output logic                     lk_valid,
	output logic                     lk_hit,
	output logic [`STLB_PA_W-1:0]    lk_pa,
	output logic [2:0]               lk_perm
);

	// Field boundaries within the virtual address
	localparam int IDX_LO = `STLB_PAGE_SHIFT;
	localparam int TAG_LO = `STLB_PAGE_SHIFT + `STLB_LOG_ENTRIES;

	// Stage 1 holding registers, aligned with the memory read data
	logic                         s1_valid;
	logic [`STLB_TAG_W-1:0]       s1_tag;
	logic [`STLB_ASID_W-1:0]      s1_asid;
	logic [`STLB_PAGE_SHIFT-1:0]  s1_off;

	// Stage 2 compare result
	logic hit;

	// ==================================================
	// Stage 1: index the entry memory
	// ==================================================

	// The memory registers the read, so the entry arrives one cycle later
	assign ram.radr = lk_va[TAG_LO-1:IDX_LO];

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			s1_valid <= 1'b0;
		end
		else
		begin
			s1_valid <= lk_req;
		end
	end

	always_ff @(posedge clk)
	begin
		s1_tag <= lk_va[`STLB_VA_W-1:TAG_LO];
		s1_asid <= lk_asid;
		s1_off <= lk_va[IDX_LO-1:0];
	end

	// ==================================================
	// Stage 2: compare and form the physical address
	// ==================================================

	// Both tag and ASID must match a valid entry
	assign hit = ram.rdat.valid & (ram.rdat.tag == s1_tag) & (ram.rdat.asid == s1_asid);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			lk_valid <= 1'b0;
			lk_hit <= 1'b0;
		end
		else
		begin
			lk_valid <= s1_valid;
			lk_hit <= s1_valid & hit;
		end
	end

	// A miss returns zero for the address and permissions
	always_ff @(posedge clk)
	begin
		lk_pa <= (s1_valid & hit) ? {ram.rdat.ppn, s1_off} : '0;
		lk_perm <= (s1_valid & hit) ? ram.rdat.perm : 3'b000;
	end

endmodule

/* stlb_top.sv */
`include "stlb_settings.svh"

module stlb_top (
	input  logic                     clk,
	input  logic                     rst,
	// Wishbone classic slave
	input  logic                     wb_cyc,
	input  logic                     wb_stb,
	input  logic                     wb_we,
	input  logic [3:0]               wb_adr,
	input  logic [31:0]              wb_dat_i,
	output logic [31:0]              wb_dat_o,
	output logic                     wb_ack,
	// Lookup port
	input  logic                     lk_req,
	input  logic [`STLB_VA_W-1:0]    lk_va,
	input  logic [`STLB_ASID_W-1:0]  lk_asid,
	output logic                     lk_valid,
	output logic                     lk_hit,
	output logic [`STLB_PA_W-1:0]    lk_pa,
	output logic [2:0]               lk_perm,
	// Status
	output logic                     busy
);

	// Controller outputs
	stlb_pkg::stlb_state_t         state;
	logic [`STLB_LOG_ENTRIES-1:0]  sweep_index;

	// Commands from the register block
	logic                          commit;
	logic [`STLB_LOG_ENTRIES-1:0]  commit_index;
	stlb_pkg::stlb_entry_t         commit_entry;
	logic                          inv_req;

	// Both ports of the entry memory
	stlb_ram_if ram_bus ();

	// ==================================================
	// Block instances
	// ==================================================

	stlb_ctrl u_ctrl (
		.clk         (clk),
		.rst         (rst),
		.inv_req     (inv_req),
		.state       (state),
		.sweep_index (sweep_index)
	);

	stlb_ad_mux u_ad_mux (
		.clk          (clk),
		.state        (state),
		.sweep_index  (sweep_index),
		.commit       (commit),
		.commit_index (commit_index),
		.commit_entry (commit_entry),
		.ram          (ram_bus.wr)
	);

	stlb_ram u_ram (
		.clk  (clk),
		.port (ram_bus.mem)
	);

	stlb_wb_regs u_wb_regs (
		.clk          (clk),
		.rst          (rst),
		.wb_cyc       (wb_cyc),
		.wb_stb       (wb_stb),
		.wb_we        (wb_we),
		.wb_adr       (wb_adr),
		.wb_dat_i     (wb_dat_i),
		.wb_dat_o     (wb_dat_o),
		.wb_ack       (wb_ack),
		.state        (state),
		.commit       (commit),
		.commit_index (commit_index),
		.commit_entry (commit_entry),
		.inv_req      (inv_req),
		.busy         (busy)
	);

	stlb_lookup u_lookup (
		.clk      (clk),
		.rst      (rst),
		.lk_req   (lk_req),
		.lk_va    (lk_va),
		.lk_asid  (lk_asid),
		.ram      (ram_bus.rd),
		.lk_valid (lk_valid),
		.lk_hit   (lk_hit),
		.lk_pa    (lk_pa),
		.lk_perm  (lk_perm)
	);

endmodule

/* tb_stlb.sv */
`include "stlb_settings.svh"

module tb_stlb;

	// Wishbone accesses may stall for a whole sweep
	localparam int BUS_TIMEOUT = 400;
	localparam int BUSY_TIMEOUT = 400;
	localparam int DRAIN_TIMEOUT = 20;
	localparam int NUM_COMMITS = 100;

	// Expected result of one lookup, queued until lk_valid arrives
	typedef struct packed {
		logic                  hit;
		logic [`STLB_PA_W-1:0] pa;
		logic [2:0]            perm;
	} lookup_exp_t;

	logic                     clk;
	logic                     rst;
	logic                     wb_cyc;
	logic                     wb_stb;
	logic                     wb_we;
	logic [3:0]               wb_adr;
	logic [31:0]              wb_dat_i;
	logic [31:0]              wb_dat_o;
	logic                     wb_ack;
	logic                     lk_req;
	logic [`STLB_VA_W-1:0]    lk_va;
	logic [`STLB_ASID_W-1:0]  lk_asid;
	logic                     lk_valid;
	logic                     lk_hit;
	logic [`STLB_PA_W-1:0]    lk_pa;
	logic [2:0]               lk_perm;
	logic                     busy;

	// Reference model of the entry memory
	stlb_pkg::stlb_entry_t model [`STLB_ENTRIES];

	// Every entry committed in the random phase, with its index
	stlb_pkg::stlb_entry_t         c_ent [NUM_COMMITS];
	logic [`STLB_LOG_ENTRIES-1:0]  c_idx [NUM_COMMITS];

	lookup_exp_t exp_q [$];
	lookup_exp_t mon_exp;

	integer      seed;
	int          errors;
	int          timeouts;
	logic [31:0] rd_data;
	int          held_cycles;

	stlb_top uut (
		.clk      (clk),
		.rst      (rst),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_i (wb_dat_i),
		.wb_dat_o (wb_dat_o),
		.wb_ack   (wb_ack),
		.lk_req   (lk_req),
		.lk_va    (lk_va),
		.lk_asid  (lk_asid),
		.lk_valid (lk_valid),
		.lk_hit   (lk_hit),
		.lk_pa    (lk_pa),
		.lk_perm  (lk_perm),
		.busy     (busy)
	);

	always #4 clk = ~clk;

	// ==================================================
	// Compare tasks
	// ==================================================

	task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp)
		begin
			errors++;
			$display("[ERROR] %s expected 0x%h got 0x%h", name, exp, act);
		end
	endtask

	task automatic check_lookup(input lookup_exp_t exp, input logic act_hit,
			input logic [`STLB_PA_W-1:0] act_pa, input logic [2:0] act_perm);
		if (act_hit !== exp.hit)
		begin
			errors++;
			$display("[ERROR] lk_hit expected 0x%h got 0x%h", exp.hit, act_hit);
		end
		if (act_pa !== exp.pa)
		begin
			errors++;
			$display("[ERROR] lk_pa expected 0x%h got 0x%h", exp.pa, act_pa);
		end
		if (act_perm !== exp.perm)
		begin
			errors++;
			$display("[ERROR] lk_perm expected 0x%h got 0x%h", exp.perm, act_perm);
		end
	endtask

	task automatic check_state(input string name, input logic exp, input logic act);
		if (act !== exp)
		begin
			errors++;
			$display("[ERROR] %s expected 0x%h got 0x%h", name, exp, act);
		end
	endtask

	// ==================================================
	// Stimulus helpers, all start and end one unit after an edge
	// ==================================================

	// Single Wishbone classic access, held until the slave acknowledges
	task automatic bus_access(input logic we, input stlb_pkg::stlb_reg_t r,
			input logic [31:0] dat, output logic [31:0] rdata, output int held);
		int   i;
		logic done;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = {r, 2'b00};
		wb_dat_i = dat;
		held = 0;
		done = 1'b0;
		rdata = '0;
		for (i = 0; i < BUS_TIMEOUT && !done; i++)
		begin
			@(posedge clk);
			#1;
			if (wb_ack)
			begin
				done = 1'b1;
				rdata = wb_dat_o;
			end
			else
			begin
				held++;
			end
		end
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		if (!done)
		begin
			timeouts++;
			$display("Wishbone access to register %0d was never acknowledged", r);
		end
	endtask

	// Stage both halves, then commit to the index
	task automatic store_entry(input logic [`STLB_LOG_ENTRIES-1:0] idx,
			input stlb_pkg::stlb_entry_t e);
		bus_access(1'b1, stlb_pkg::REG_HI,
			{{(32 - 1 - `STLB_ASID_W - `STLB_TAG_W){1'b0}}, e.valid, e.asid, e.tag},
			rd_data, held_cycles);
		bus_access(1'b1, stlb_pkg::REG_LO,
			{{(32 - `STLB_PPN_W - 3){1'b0}}, e.ppn, e.perm}, rd_data, held_cycles);
		bus_access(1'b1, stlb_pkg::REG_INDEX,
			{{(32 - `STLB_LOG_ENTRIES){1'b0}}, idx}, rd_data, held_cycles);
		model[idx] = e;
	endtask

	// One lookup request, expected result taken from the model
	task automatic issue_lookup(input logic [`STLB_TAG_W-1:0] tag,
			input logic [`STLB_LOG_ENTRIES-1:0] idx, input logic [`STLB_PAGE_SHIFT-1:0] off,
			input logic [`STLB_ASID_W-1:0] asid);
		lookup_exp_t           e;
		stlb_pkg::stlb_entry_t m;
		m = model[idx];
		e.hit = m.valid && (m.tag == tag) && (m.asid == asid);
		e.pa = e.hit ? {m.ppn, off} : '0;
		e.perm = e.hit ? m.perm : 3'b000;
		lk_req = 1'b1;
		lk_va = {tag, idx, off};
		lk_asid = asid;
		exp_q.push_back(e);
		@(posedge clk);
		#1;
	endtask

	task automatic drain_lookups();
		int i;
		lk_req = 1'b0;
		for (i = 0; i < DRAIN_TIMEOUT && exp_q.size() != 0; i++)
		begin
			@(posedge clk);
			#1;
		end
		if (exp_q.size() != 0)
		begin
			timeouts++;
			$display("Lookup results did not all arrive in time");
			exp_q.delete();
		end
	endtask

	task automatic wait_busy(input logic level);
		int i;
		for (i = 0; i < BUSY_TIMEOUT && busy !== level; i++)
		begin
			@(posedge clk);
			#1;
		end
		if (busy !== level)
		begin
			timeouts++;
			$display("Busy flag did not reach the expected level in time");
		end
	endtask

	task automatic idle_cycles(input int n);
		repeat (n)
		begin
			@(posedge clk);
			#1;
		end
	endtask

	// ==================================================
	// Lookup result monitor
	// ==================================================

	// Sampled mid-cycle, where the registered outputs are settled
	always @(negedge clk)
	begin
		if (!rst && lk_valid)
		begin
			if (exp_q.size() == 0)
			begin
				errors++;
				$display("A lookup result arrived with no request outstanding");
			end
			else
			begin
				mon_exp = exp_q.pop_front();
				check_lookup(mon_exp, lk_hit, lk_pa, lk_perm);
			end
		end
	end

	// ==================================================
	// Main sequence
	// ==================================================

	initial
	begin : main
		logic [31:0]                   rnd;
		logic [31:0]                   wdat;
		stlb_pkg::stlb_entry_t         e;
		logic [`STLB_TAG_W-1:0]        tag;
		logic [`STLB_ASID_W-1:0]       asid;
		int                            pick;
		int                            kind;
		clk = 1'b0;
		rst = 1'b1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_i = '0;
		lk_req = 1'b0;
		lk_va = '0;
		lk_asid = '0;
		seed = 31563;
		errors = 0;
		timeouts = 0;
		for (int i = 0; i < `STLB_ENTRIES; i++)
		begin
			model[i] = '0;
		end
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;

		// Reset sweep clears the memory, so everything misses
		wait_busy(1'b0);
		// The last sweep write lands in the memory one cycle after busy falls
		idle_cycles(2);
		for (int i = 0; i < 40; i++)
		begin
			rnd = $random(seed);
			issue_lookup(rnd[31:21], rnd[20:13], rnd[12:0], rnd[7:0] ^ rnd[31:24]);
		end
		drain_lookups();

		// Staging registers read back through their own field layout
		// Hi holds valid, ASID and tag in bits 19:0, lo holds ppn and perm in bits 21:0
		wdat = $random(seed);
		bus_access(1'b1, stlb_pkg::REG_HI, wdat, rd_data, held_cycles);
		bus_access(1'b0, stlb_pkg::REG_HI, '0, rd_data, held_cycles);
		check_word("wb_dat_o (REG_HI)", wdat & 32'h000F_FFFF, rd_data);
		wdat = $random(seed);
		bus_access(1'b1, stlb_pkg::REG_LO, wdat, rd_data, held_cycles);
		bus_access(1'b0, stlb_pkg::REG_LO, '0, rd_data, held_cycles);
		check_word("wb_dat_o (REG_LO)", wdat & 32'h003F_FFFF, rd_data);

		// Random commits of valid entries
		for (int i = 0; i < NUM_COMMITS; i++)
		begin
			rnd = $random(seed);
			e.valid = 1'b1;
			e.asid = rnd[7:0];
			e.tag = rnd[18:8];
			e.perm = rnd[21:19];
			rnd = $random(seed);
			e.ppn = rnd[18:0];
			c_ent[i] = e;
			c_idx[i] = rnd[26:19];
			store_entry(c_idx[i], e);
		end
		bus_access(1'b0, stlb_pkg::REG_INDEX, '0, rd_data, held_cycles);
		check_word("wb_dat_o (REG_INDEX)", {24'h0, c_idx[NUM_COMMITS-1]}, rd_data);
		idle_cycles(4);

		// Back-to-back lookups mixing hits, wrong tags and wrong ASIDs
		for (int i = 0; i < 300; i++)
		begin
			pick = {$random(seed)} % NUM_COMMITS;
			kind = {$random(seed)} % 3;
			rnd = $random(seed);
			tag = c_ent[pick].tag;
			asid = c_ent[pick].asid;
			if (kind == 1)
			begin
				tag = tag ^ (rnd[23:13] | 11'd1);
			end
			else if (kind == 2)
			begin
				asid = asid ^ (rnd[31:24] | 8'd1);
			end
			issue_lookup(tag, c_idx[pick], rnd[12:0], asid);
		end
		drain_lookups();

		// Clearing valid on the last committed entry turns its hit into a miss
		e = c_ent[NUM_COMMITS-1];
		issue_lookup(e.tag, c_idx[NUM_COMMITS-1], 13'h0a5, e.asid);
		drain_lookups();
		e.valid = 1'b0;
		store_entry(c_idx[NUM_COMMITS-1], e);
		idle_cycles(4);
		issue_lookup(e.tag, c_idx[NUM_COMMITS-1], 13'h0a5, e.asid);
		drain_lookups();

		// Invalidate-all, with a write stalled for the whole sweep
		bus_access(1'b1, stlb_pkg::REG_CMD, 32'h1, rd_data, held_cycles);
		for (int i = 0; i < `STLB_ENTRIES; i++)
		begin
			model[i] = '0;
		end
		// The sweep state is entered at the edge after the ack
		idle_cycles(1);
		check_state("busy", 1'b1, busy);
		wdat = $random(seed);
		bus_access(1'b1, stlb_pkg::REG_HI, wdat, rd_data, held_cycles);
		check_state("busy", 1'b0, busy);
		if (held_cycles < 200)
		begin
			errors++;
			$display("A Wishbone write during the sweep was acknowledged too early");
		end
		bus_access(1'b0, stlb_pkg::REG_HI, '0, rd_data, held_cycles);
		check_word("wb_dat_o (REG_HI)", wdat & 32'h000F_FFFF, rd_data);
		for (int i = 0; i < NUM_COMMITS; i++)
		begin
			issue_lookup(c_ent[i].tag, c_idx[i], 13'h1f0, c_ent[i].asid);
		end
		drain_lookups();

		// Busy reads back clear in normal operation
		bus_access(1'b0, stlb_pkg::REG_CMD, '0, rd_data, held_cycles);
		check_word("wb_dat_o (REG_CMD)", 32'h0, rd_data);

		idle_cycles(2);
		$display("Errors: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0)
		begin
			$display("Result: PASSED");
		end
		else
		begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

/* filelist.f */
+incdir+.
stlb_pkg.sv
stlb_ram_if.sv
stlb_ctrl.sv
stlb_ad_mux.sv
stlb_ram.sv
stlb_wb_regs.sv
stlb_lookup.sv
stlb_top.sv
tb_stlb.sv

/* run_sim.sh */
#!/bin/sh
# Build the STLB testbench with Verilator, run it and judge the log
set -e

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing -f filelist.f --top-module tb_stlb -o sim_stlb

./obj_dir/sim_stlb | tee sim.log

if grep -qx "Result: PASSED" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi
